/* files.f */
+incdir+hw
hw/fc_pkg.sv
hw/fc_event_capture.sv
hw/fc_irq_pending.sv
hw/fc_subsystem.sv
test/tb_fc_subsystem.sv

/* hw/fc_defs.svh */
`ifndef FC_DEFS_SVH
`define FC_DEFS_SVH

// ********************
// Interrupt line setup
// ********************

// Number of event lines coming in and interrupt lines going to the core
`define FC_NUM_IRQ 32

// Lines set here are passed through as levels and never become sticky.
// Line 11 carries the event generator output, which is already a level.
`define FC_LEVEL_MASK 32'h0000_0800

`endif

/* hw/fc_event_capture.sv */
`include "fc_defs.svh"

module fc_event_capture (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`FC_NUM_IRQ-1:0] events_i,
  output fc_pkg::irq_evt_t       evt_o
);

  localparam logic [`FC_NUM_IRQ-1:0] level_mask = `FC_LEVEL_MASK;

  // First stage samples the pins and second stage keeps the previous sample
  logic [`FC_NUM_IRQ-1:0] evt_q1;
  logic [`FC_NUM_IRQ-1:0] evt_q2;
  logic [`FC_NUM_IRQ-1:0] evt_rise;

  // ********************
  // Sampling stages
  // ********************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q1 <= '0;
      evt_q2 <= '0;
    end else begin
      evt_q1 <= events_i;
      evt_q2 <= evt_q1;
    end
  end

  // Rising edge seen between the two stages
  assign evt_rise = evt_q1 & ~evt_q2;

  // ********************
  // Line classification
  // ********************

  // Edge lines pulse for one cycle and ask to be held.
  // Level lines follow the first stage and never stick.
  always_comb begin
    for (int i = 0; i < `FC_NUM_IRQ; i++) begin
      if (level_mask[i]) begin
        evt_o.set[i]  = evt_q1[i];
        evt_o.hold[i] = 1'b0;
      end else begin
        evt_o.set[i]  = evt_rise[i];
        evt_o.hold[i] = 1'b1;
      end
    end
  end

endmodule

/* hw/fc_irq_pending.sv */
`include "fc_defs.svh"

module fc_irq_pending (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fc_pkg::irq_evt_t       evt_i,
  input  logic                   irq_ack_i,
  input  logic [4:0]             irq_ack_id_i,
  output logic [`FC_NUM_IRQ-1:0] irq_o
);

  // One-hot clear derived from the core's acknowledge
  logic [`FC_NUM_IRQ-1:0] ack_clr;
  // Next state and current state of the pending vector
  logic [`FC_NUM_IRQ-1:0] irq_d;
  logic [`FC_NUM_IRQ-1:0] irq_q;

  // ********************
  // Acknowledge decode
  // ********************

  always_comb begin
    ack_clr = '0;
    if (irq_ack_i) begin
      ack_clr[irq_ack_id_i] = 1'b1;
    end
  end

  // ********************
  // Pending update
  // ********************

  // On sticky lines a clear beats a new set arriving in the same cycle.
  // Non-sticky lines just copy set and ignore acks.
  always_comb begin
    for (int i = 0; i < `FC_NUM_IRQ; i++) begin
      if (!evt_i.hold[i]) begin
        irq_d[i] = evt_i.set[i];
      end else if (ack_clr[i]) begin
        irq_d[i] = 1'b0;
      end else begin
        irq_d[i] = irq_q[i] | evt_i.set[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o = irq_q;

  // The core may only acknowledge a sticky line that it sees pending
  ack_of_pending_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (irq_ack_i && evt_i.hold[irq_ack_id_i]) |-> irq_q[irq_ack_id_i]
  ) else $error("acknowledge of line %0d which is not pending", irq_ack_id_i);

endmodule

/* hw/fc_pkg.sv */
`include "fc_defs.svh"

package fc_pkg;

  // ********************
  // Interrupt path
  // ********************

  // Per-line capture result handed from the event capture to the pending register
  typedef struct packed {
    logic [`FC_NUM_IRQ-1:0] set;
    logic [`FC_NUM_IRQ-1:0] hold;
  } irq_evt_t;

  // ********************
  // Core side buses
  // ********************

  // Data request as issued by the core
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } core_data_req_t;

  // Fetch request, always a full word read
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } core_instr_req_t;

  // Shared by the data and the instruction side
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } core_rsp_t;

  // ********************
  // L2 crossbar side
  // ********************

  // Write enable is active low on the crossbar
  typedef struct packed {
    logic        req;
    logic [31:0] add;
    logic        wen;
    logic [3:0]  be;
    logic [31:0] wdata;
  } tcdm_req_t;

  // r_opc flags a failed access
  typedef struct packed {
    logic        gnt;
    logic        r_valid;
    logic [31:0] r_rdata;
    logic        r_opc;
  } tcdm_rsp_t;

endpackage

/* hw/fc_subsystem.sv */
`include "fc_defs.svh"

module fc_subsystem (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Events in, interrupt vector and acknowledge to and from the core
  input  logic [`FC_NUM_IRQ-1:0]  events_i,
  output logic [`FC_NUM_IRQ-1:0]  irq_o,
  input  logic                    irq_ack_i,
  input  logic [4:0]              irq_ack_id_i,

  // Core data side
  input  fc_pkg::core_data_req_t  core_data_req_i,
  output fc_pkg::core_rsp_t       core_data_rsp_o,

  // Core fetch side
  input  fc_pkg::core_instr_req_t core_instr_req_i,
  output fc_pkg::core_rsp_t       core_instr_rsp_o,

  // L2 crossbar data port
  output fc_pkg::tcdm_req_t       l2_data_req_o,
  input  fc_pkg::tcdm_rsp_t       l2_data_rsp_i,

  // L2 crossbar instruction port
  output fc_pkg::tcdm_req_t       l2_instr_req_o,
  input  fc_pkg::tcdm_rsp_t       l2_instr_rsp_i
);

  // Capture result feeding the pending register
  fc_pkg::irq_evt_t irq_evt;

  // ********************
  // Interrupt capture
  // ********************

  fc_event_capture i_event_capture (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .events_i (events_i),
    .evt_o    (irq_evt)
  );

  fc_irq_pending i_irq_pending (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .evt_i        (irq_evt),
    .irq_ack_i    (irq_ack_i),
    .irq_ack_id_i (irq_ack_id_i),
    .irq_o        (irq_o)
  );

  // ********************
  // L2 data port
  // ********************

  // Only the write enable flips polarity on the way to L2
  assign l2_data_req_o.req   = core_data_req_i.req;
  assign l2_data_req_o.add   = core_data_req_i.addr;
  assign l2_data_req_o.wen   = ~core_data_req_i.we;
  assign l2_data_req_o.be    = core_data_req_i.be;
  assign l2_data_req_o.wdata = core_data_req_i.wdata;

  // Grant passes straight through and the core holds req until it sees it
  assign core_data_rsp_o.gnt    = l2_data_rsp_i.gnt;
  assign core_data_rsp_o.rvalid = l2_data_rsp_i.r_valid;
  assign core_data_rsp_o.rdata  = l2_data_rsp_i.r_rdata;
  assign core_data_rsp_o.err    = l2_data_rsp_i.r_opc;

  // ********************
  // L2 instruction port
  // ********************

  // Fetches are full word reads, so the write fields are tied off
  assign l2_instr_req_o.req   = core_instr_req_i.req;
  assign l2_instr_req_o.add   = core_instr_req_i.addr;
  assign l2_instr_req_o.wen   = 1'b1;
  assign l2_instr_req_o.be    = 4'b1111;
  assign l2_instr_req_o.wdata = '0;

  assign core_instr_rsp_o.gnt    = l2_instr_rsp_i.gnt;
  assign core_instr_rsp_o.rvalid = l2_instr_rsp_i.r_valid;
  assign core_instr_rsp_o.rdata  = l2_instr_rsp_i.r_rdata;
  assign core_instr_rsp_o.err    = l2_instr_rsp_i.r_opc;

  // ********************
  // Bus checks
  // ********************

  // Read data only comes back after a request
  data_rvalid_after_gnt_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_data_rsp_o.rvalid |-> $past(core_data_req_i.req) || $past(core_data_rsp_o.rvalid)
  ) else $error("data rvalid without a preceding request");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fc_subsystem testbench with Verilator.
# Exit status is zero only when the run prints the pass line.

set -u

cd "$(dirname "$0")" || exit 1

top=tb_fc_subsystem
exe=sim_${top}

# Build
verilator --binary --timing --assert \
  --top-module "${top}" \
  -f files.f \
  -o "${exe}"
status=$?
if [ ${status} -ne 0 ]; then
  echo "verilator build failed with status ${status}"
  exit 1
fi

# Run
output=$(./obj_dir/${exe})
status=$?
echo "${output}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

# Verdict
if echo "${output}" | grep -qx "RESULT: PASS"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* test/tb_fc_subsystem.sv */
`include "fc_defs.svh"

module tb_fc_subsystem;

  localparam int period       = 20;
  localparam int reset_cycles = 16;
  localparam int level_line   = 11;
  localparam int cyc_idle     = 20;
  localparam int cyc_data     = 400;
  localparam int cyc_instr    = 400;
  localparam int cyc_edge     = 200;
  localparam int cyc_ack      = 600;
  localparam int cyc_level    = 300;
  localparam int total_cycles = reset_cycles + cyc_idle + cyc_data + cyc_instr
                                + cyc_edge + cyc_ack + cyc_level;
  localparam logic [`FC_NUM_IRQ-1:0] edge_lines = ~(32'd1 << level_line);

  logic                    clk;
  logic                    rst_n;
  logic [`FC_NUM_IRQ-1:0]  events;
  logic [`FC_NUM_IRQ-1:0]  irq;
  logic                    irq_ack;
  logic [4:0]              irq_ack_id;
  fc_pkg::core_data_req_t  dreq;
  fc_pkg::core_rsp_t       drsp;
  fc_pkg::core_instr_req_t ireq;
  fc_pkg::core_rsp_t       irsp;
  fc_pkg::tcdm_req_t       l2_dreq;
  fc_pkg::tcdm_rsp_t       l2_drsp;
  fc_pkg::tcdm_req_t       l2_ireq;
  fc_pkg::tcdm_rsp_t       l2_irsp;

  // Reference model state
  logic [`FC_NUM_IRQ-1:0] m_q1;
  logic [`FC_NUM_IRQ-1:0] m_q2;
  logic [`FC_NUM_IRQ-1:0] m_pend;
  logic                   lvl_prev;
  // The L2 only answers after a request, so the last drive is kept
  logic                   prev_req;
  logic                   prev_rvalid;
  integer                 seed;
  int                     err_cnt;
  int                     check_cnt;
  int                     tests_run;

  fc_subsystem UUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .events_i         (events),
    .irq_o            (irq),
    .irq_ack_i        (irq_ack),
    .irq_ack_id_i     (irq_ack_id),
    .core_data_req_i  (dreq),
    .core_data_rsp_o  (drsp),
    .core_instr_req_i (ireq),
    .core_instr_rsp_o (irsp),
    .l2_data_req_o    (l2_dreq),
    .l2_data_rsp_i    (l2_drsp),
    .l2_instr_req_o   (l2_ireq),
    .l2_instr_rsp_i   (l2_irsp)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // ********************
  // Reference model
  // ********************

  // Advances the interrupt path by one clock edge with the inputs sampled there
  task automatic update_model();
    logic [`FC_NUM_IRQ-1:0] rise;
    rise = m_q1 & ~m_q2;
    for (int i = 0; i < `FC_NUM_IRQ; i++) begin
      if (i == level_line) begin
        m_pend[i] = m_q1[i];
      end else if (irq_ack && irq_ack_id == 5'(i)) begin
        m_pend[i] = 1'b0;
      end else begin
        m_pend[i] = m_pend[i] | rise[i];
      end
    end
    m_q2 = m_q1;
    m_q1 = events;
  endtask

  // Finds the first set bit from start on with wraparound
  // Bit 5 of the result flags a hit
  function automatic logic [5:0] pick_line(logic [31:0] cand, logic [4:0] start);
    logic [4:0] idx;
    for (int k = 0; k < 32; k++) begin
      idx = start + 5'(k);
      if (cand[idx]) return {1'b1, idx};
    end
    return 6'd0;
  endfunction

  // ********************
  // Stimulus
  // ********************

  task automatic drive_inputs(int mode);
    logic [31:0]             r;
    logic [31:0]             ev;
    logic [5:0]              pick;
    logic                    ack;
    logic [4:0]              ack_id;
    fc_pkg::core_data_req_t  d;
    fc_pkg::tcdm_rsp_t       ds;
    fc_pkg::core_instr_req_t f;
    fc_pkg::tcdm_rsp_t       fs;
    r = $random(seed);
    d = '0;
    ds = '0;
    f = '0;
    fs = '0;
    ev = '0;
    ack = 1'b0;
    ack_id = '0;
    pick = '0;
    if (mode == 2) begin
      d.req      = r[0];
      d.we       = r[1];
      d.be       = r[5:2];
      d.addr     = $random(seed);
      d.wdata    = $random(seed);
      ds.gnt     = r[6];
      ds.r_valid = r[7] & (prev_req | prev_rvalid);
      ds.r_rdata = $random(seed);
      ds.r_opc   = r[8];
    end
    if (mode == 3) begin
      f.req      = r[0];
      f.addr     = $random(seed);
      fs.gnt     = r[6];
      fs.r_valid = r[7];
      fs.r_rdata = $random(seed);
      fs.r_opc   = r[8];
    end
    if (mode == 4 || mode == 5) begin
      // About one line in sixteen rises per cycle
      ev = $random(seed);
      ev = ev & $random(seed);
      ev = ev & $random(seed);
      ev = ev & $random(seed);
      ev = ev & edge_lines;
    end
    if (mode == 5 && r[10]) begin
      // Often aim at a pending line that sees a new rise at the same edge
      if (r[11]) pick = pick_line(m_pend & m_q1 & ~m_q2 & edge_lines, r[16:12]);
      if (!pick[5]) pick = pick_line(m_pend & edge_lines, r[16:12]);
      ack    = pick[5];
      ack_id = pick[4:0];
    end
    if (mode == 6) begin
      ev[level_line] = r[9];
      ack            = r[12];
      ack_id         = 5'(level_line);
    end
    prev_req    = d.req;
    prev_rvalid = ds.r_valid;
    dreq       <= d;
    l2_drsp    <= ds;
    ireq       <= f;
    l2_irsp    <= fs;
    events     <= ev;
    irq_ack    <= ack;
    irq_ack_id <= ack_id;
  endtask

  // ********************
  // Checks
  // ********************

  task automatic report_error(string what, string detail);
    $display("** Error [%0t] %s: %s", $time, what, detail);
    err_cnt++;
  endtask

  task automatic check_outputs(int mode);
    fc_pkg::tcdm_req_t exp_dreq;
    fc_pkg::core_rsp_t exp_drsp;
    fc_pkg::tcdm_req_t exp_ireq;
    fc_pkg::core_rsp_t exp_irsp;
    exp_dreq.req     = dreq.req;
    exp_dreq.add     = dreq.addr;
    exp_dreq.wen     = !dreq.we;
    exp_dreq.be      = dreq.be;
    exp_dreq.wdata   = dreq.wdata;
    exp_drsp.gnt     = l2_drsp.gnt;
    exp_drsp.rvalid  = l2_drsp.r_valid;
    exp_drsp.rdata   = l2_drsp.r_rdata;
    exp_drsp.err     = l2_drsp.r_opc;
    exp_ireq.req     = ireq.req;
    exp_ireq.add     = ireq.addr;
    exp_ireq.wen     = 1'b1;
    exp_ireq.be      = 4'hf;
    exp_ireq.wdata   = 32'h0;
    exp_irsp.gnt     = l2_irsp.gnt;
    exp_irsp.rvalid  = l2_irsp.r_valid;
    exp_irsp.rdata   = l2_irsp.r_rdata;
    exp_irsp.err     = l2_irsp.r_opc;
    check_cnt += 5;
    assert (irq == m_pend)
      else report_error("irq_o", $sformatf("got %h, expected %h", irq, m_pend));
    assert (l2_dreq == exp_dreq)
      else report_error("L2 data request", $sformatf("got %h, expected %h", l2_dreq, exp_dreq));
    assert (drsp == exp_drsp)
      else report_error("data response", $sformatf("got %h, expected %h", drsp, exp_drsp));
    assert (l2_ireq == exp_ireq)
      else report_error("L2 fetch request", $sformatf("got %h, expected %h", l2_ireq, exp_ireq));
    assert (irsp == exp_irsp)
      else report_error("fetch response", $sformatf("got %h, expected %h", irsp, exp_irsp));
    if (mode == 1) begin
      check_cnt++;
      assert (!l2_dreq.req && !l2_ireq.req)
        else report_error("idle L2 req", $sformatf("data %b, fetch %b, expected 0",
                                                   l2_dreq.req, l2_ireq.req));
    end
    if (mode == 6) begin
      check_cnt++;
      assert (irq[level_line] == lvl_prev)
        else report_error("level line 11", $sformatf("got %b, expected %b",
                                                     irq[level_line], lvl_prev));
    end
  endtask

  task automatic run_test(int num, string name, int mode, int cycles, bit check_first);
    int err_start;
    err_start = err_cnt;
    if (check_first) check_outputs(mode);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk);
      lvl_prev = m_q1[level_line];
      update_model();
      drive_inputs(mode);
      @(negedge clk);
      check_outputs(mode);
    end
    tests_run++;
    $display("test %0d %s: %0d cycles, %0d errors", num, name, cycles, err_cnt - err_start);
  endtask

  // ********************
  // Main sequence
  // ********************

  initial begin
    seed        = 32'hd025_fac5;
    rst_n       = 1'b0;
    events      = '0;
    irq_ack     = 1'b0;
    irq_ack_id  = '0;
    dreq        = '0;
    ireq        = '0;
    l2_drsp     = '0;
    l2_irsp     = '0;
    m_q1        = '0;
    m_q2        = '0;
    m_pend      = '0;
    lvl_prev    = 1'b0;
    prev_req    = 1'b0;
    prev_rvalid = 1'b0;
    err_cnt     = 0;
    check_cnt   = 0;
    tests_run   = 0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    run_test(1, "reset and idle", 1, cyc_idle, 1'b1);
    run_test(2, "data port mapping", 2, cyc_data, 1'b0);
    run_test(3, "fetch port mapping", 3, cyc_instr, 1'b0);
    run_test(4, "edge capture", 4, cyc_edge, 1'b0);
    run_test(5, "acknowledge clear", 5, cyc_ack, 1'b0);
    run_test(6, "level line", 6, cyc_level, 1'b0);
    $display("%0d tests, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Stops a hung run after twice the length of all tests
  initial begin
    #(total_cycles * 2 * period);
    $display("timeout: tests did not finish within %0d cycles", total_cycles * 2);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
